/* include/periph_glue_config.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral glue configuration
// Port addresses, window segments, special codes and reset values
// ~~~~~~~~~~~~~~~~~~~~

`ifndef PERIPH_GLUE_CONFIG_SVH
`define PERIPH_GLUE_CONFIG_SVH

// I/O port map
`define EMS_PORT_BASE      16'h0260
`define LPT_DATA_PORT      16'h0378
`define NMI_PORT_BASE      16'h00A0

// EMS control byte that switches a slot off
`define EMS_DISABLE_CODE   8'hFF

// Upper address nibbles of the window bases
`define EMS_SEG_A          4'hA
`define EMS_SEG_C          4'hC
`define EMS_SEG_D          4'hD

// Register contents after reset
`define LPT_RESET_VALUE    8'hFF
`define NMI_RESET_VALUE    8'hFF

// Read-back bus value when no register is read
`define IDLE_READ_VALUE    8'h00

`endif

/* rtl/periph_glue_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral glue types
// EMS control byte, seen raw or split into flag and page
// ~~~~~~~~~~~~~~~~~~~~

package periph_glue_pkg;

    // Page part of an EMS control byte
    typedef struct packed {
        // Set when the byte carries no page
        logic       no_page;
        logic [6:0] page;
    } ems_ctrl_fields_t;

    // One EMS byte, decoded two ways
    // The raw view is compared against the disable code
    // The field view gives the page number and its flag
    typedef union packed {
        logic [7:0]       raw;
        ems_ctrl_fields_t fields;
    } ems_ctrl_u;

endpackage

/* rtl/port_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// I/O port decode
// Address and strobes to per-register read and write strobes
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_glue_config.svh"

module port_decode (
    input  logic [19:0] address_i,
    input  logic        io_read_n_i,
    input  logic        io_write_n_i,
    input  logic        address_enable_n_i,
    input  logic        ems_enabled_i,
    input  logic        tandy_mode_i,
    output logic        ems_write_o,
    output logic        ems_read_o,
    output logic        lpt_write_o,
    output logic        lpt_read_o,
    output logic        nmi_write_o,
    output logic        nmi_read_o,
    output logic        mem_cycle_o
);

    localparam logic [15:0] EMS_BASE = `EMS_PORT_BASE;
    localparam logic [15:0] LPT_PORT = `LPT_DATA_PORT;
    localparam logic [15:0] NMI_BASE = `NMI_PORT_BASE;

    logic io_read;
    logic io_write;
    logic ems_select;
    logic lpt_select;
    logic nmi_select;

    assign io_read  = ~io_read_n_i;
    assign io_write = ~io_write_n_i;

    // No I/O strobe means the bus is doing a memory access
    assign mem_cycle_o = ~(io_read | io_write);

    // EMS ports 260h..263h only while the mapper is switched on
    assign ems_select = ~address_enable_n_i && ems_enabled_i
                        && (address_i[15:2] == EMS_BASE[15:2]);

    // Exact match on the printer data port
    assign lpt_select = ~address_enable_n_i && (address_i[15:0] == LPT_PORT);

    // NMI mask A0h..A7h exists on Tandy only
    assign nmi_select = ~address_enable_n_i && tandy_mode_i
                        && (address_i[15:3] == NMI_BASE[15:3]);

    // Split each select into read and write strobes
    assign ems_write_o = ems_select & io_write;
    assign ems_read_o  = ems_select & io_read;
    assign lpt_write_o = lpt_select & io_write;
    assign lpt_read_o  = lpt_select & io_read;
    assign nmi_write_o = nmi_select & io_write;
    assign nmi_read_o  = nmi_select & io_read;

endmodule

/* rtl/ems_page_mapper.sv */
// ~~~~~~~~~~~~~~~~~~~~
// EMS page mapper
// Four page registers, their read-back and the memory window hits
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_glue_config.svh"

module ems_page_mapper
    import periph_glue_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [19:0] address_i,
    input  logic [7:0]  data_i,
    input  logic        ems_write_i,
    input  logic        mem_cycle_i,
    input  logic [1:0]  ems_base_i,
    output ems_ctrl_u   ems_read_data_o,
    output logic [3:0]  ems_window_hit_o
);

    // Page storage with one entry per 16 KB window
    logic [3:0][6:0] page_q;
    logic [3:0]      enable_q;

    // First write stage
    logic [1:0]      wr_slot_q;
    logic            wr_pending_q;
    logic [6:0]      wr_page_q;
    logic            wr_enable_q;

    ems_ctrl_u       ctrl_byte;
    logic [1:0]      addr_slot;
    logic [6:0]      next_page;
    logic            next_enable;
    logic [3:0]      base_nibble;

    assign ctrl_byte = data_i;
    assign addr_slot = address_i[1:0];

    // Decode the control byte
    always_comb begin
        if (ctrl_byte.raw == `EMS_DISABLE_CODE) begin
            next_page   = ctrl_byte.fields.page;
            next_enable = 1'b0;
        end else if (!ctrl_byte.fields.no_page) begin
            next_page   = ctrl_byte.fields.page;
            next_enable = 1'b1;
        end else begin
            // Any other byte leaves the slot as it is
            next_page   = page_q[addr_slot];
            next_enable = enable_q[addr_slot];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_slot_q    <= 2'b00;
            wr_pending_q <= 1'b0;
            wr_page_q    <= 7'h00;
            wr_enable_q  <= 1'b0;
        end else begin
            wr_slot_q    <= addr_slot;
            wr_pending_q <= ems_write_i;
            wr_page_q    <= next_page;
            wr_enable_q  <= next_enable;
        end
    end

    // Second stage updates the slot
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_q   <= '0;
            enable_q <= '0;
        end else if (wr_pending_q) begin
            page_q[wr_slot_q]   <= wr_page_q;
            enable_q[wr_slot_q] <= wr_enable_q;
        end
    end

    // Read-back of the addressed slot
    always_comb begin
        if (enable_q[addr_slot]) begin
            ems_read_data_o.fields.no_page = 1'b0;
            ems_read_data_o.fields.page    = page_q[addr_slot];
        end else begin
            ems_read_data_o.raw = `EMS_DISABLE_CODE;
        end
    end

    // Window base segment
    always_comb begin
        case (ems_base_i)
            2'd0:    base_nibble = `EMS_SEG_A;
            2'd1:    base_nibble = `EMS_SEG_C;
            default: base_nibble = `EMS_SEG_D;
        endcase
    end

    // Each slot covers one 16 KB block above the base
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            ems_window_hit_o[n] = mem_cycle_i && enable_q[n]
                                  && (address_i[19:14] == {base_nibble, 2'(n)});
        end
    end

endmodule

/* rtl/port_latches.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port latches
// Printer data latch and Tandy NMI mask register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_glue_config.svh"

module port_latches (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] data_i,
    input  logic       lpt_write_i,
    input  logic       nmi_write_i,
    output logic [7:0] lpt_data_o,
    output logic [7:0] nmi_data_o
);

    logic [7:0] lpt_q;
    logic [7:0] nmi_q;

    // Printer data port 378h
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_q <= `LPT_RESET_VALUE;
        end else if (lpt_write_i) begin
            lpt_q <= data_i;
        end
    end

    // NMI mask at Tandy ports A0h..A7h
    // Only stored and read back here
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nmi_q <= `NMI_RESET_VALUE;
        end else if (nmi_write_i) begin
            nmi_q <= data_i;
        end
    end

    assign lpt_data_o = lpt_q;
    assign nmi_data_o = nmi_q;

endmodule

/* rtl/read_data_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Read-back mux
// Registered select of read data and the chipset-drive flag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_glue_config.svh"

module read_data_mux
    import periph_glue_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       ems_read_i,
    input  logic       lpt_read_i,
    input  logic       nmi_read_i,
    input  ems_ctrl_u  ems_read_data_i,
    input  logic [7:0] lpt_data_i,
    input  logic [7:0] nmi_data_i,
    output logic [7:0] data_o,
    output logic       data_valid_o
);

    // Priority EMS, then printer, then NMI mask
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_o       <= `IDLE_READ_VALUE;
            data_valid_o <= 1'b0;
        end else if (ems_read_i) begin
            data_o       <= ems_read_data_i.raw;
            data_valid_o <= 1'b1;
        end else if (lpt_read_i) begin
            data_o       <= lpt_data_i;
            data_valid_o <= 1'b1;
        end else if (nmi_read_i) begin
            data_o       <= nmi_data_i;
            data_valid_o <= 1'b1;
        end else begin
            // Nobody drives the bus
            data_o       <= `IDLE_READ_VALUE;
            data_valid_o <= 1'b0;
        end
    end

endmodule

/* rtl/periph_glue_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral glue top
// I/O decode, EMS mapper, port latches and read-back bus
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module periph_glue_top
    import periph_glue_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [19:0] address_i,
    input  logic [7:0]  data_i,
    input  logic        io_read_n_i,
    input  logic        io_write_n_i,
    input  logic        address_enable_n_i,
    input  logic        ems_enabled_i,
    input  logic        tandy_mode_i,
    input  logic [1:0]  ems_base_i,
    output logic [7:0]  data_o,
    output logic        data_valid_o,
    output logic [3:0]  ems_window_hit_o
);

    logic      ems_write;
    logic      ems_read;
    logic      lpt_write;
    logic      lpt_read;
    logic      nmi_write;
    logic      nmi_read;
    logic      mem_cycle;
    ems_ctrl_u ems_read_data;
    logic [7:0] lpt_data;
    logic [7:0] nmi_data;

    port_decode i_port_decode (
        .address_i          (address_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_mode_i       (tandy_mode_i),
        .ems_write_o        (ems_write),
        .ems_read_o         (ems_read),
        .lpt_write_o        (lpt_write),
        .lpt_read_o         (lpt_read),
        .nmi_write_o        (nmi_write),
        .nmi_read_o         (nmi_read),
        .mem_cycle_o        (mem_cycle)
    );

    ems_page_mapper i_ems_page_mapper (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .data_i             (data_i),
        .ems_write_i        (ems_write),
        .mem_cycle_i        (mem_cycle),
        .ems_base_i         (ems_base_i),
        .ems_read_data_o    (ems_read_data),
        .ems_window_hit_o   (ems_window_hit_o)
    );

    port_latches i_port_latches (
        .clock              (clock),
        .reset              (reset),
        .data_i             (data_i),
        .lpt_write_i        (lpt_write),
        .nmi_write_i        (nmi_write),
        .lpt_data_o         (lpt_data),
        .nmi_data_o         (nmi_data)
    );

    read_data_mux i_read_data_mux (
        .clock              (clock),
        .reset              (reset),
        .ems_read_i         (ems_read),
        .lpt_read_i         (lpt_read),
        .nmi_read_i         (nmi_read),
        .ems_read_data_i    (ems_read_data),
        .lpt_data_i         (lpt_data),
        .nmi_data_i         (nmi_data),
        .data_o             (data_o),
        .data_valid_o       (data_valid_o)
    );

endmodule

/* test/periph_glue_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral glue testbench
// Replays bus cycles from the test file, checks read-back and window hits
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_glue_config.svh"

module periph_glue_tb
    import periph_glue_pkg::*;
();

    localparam string TEST_FILE = "test/periph_glue_tests.txt";

    logic        clock;
    logic        reset;
    logic [19:0] address_i;
    logic [7:0]  data_i;
    logic        io_read_n_i;
    logic        io_write_n_i;
    logic        address_enable_n_i;
    logic        ems_enabled_i;
    logic        tandy_mode_i;
    logic [1:0]  ems_base_i;
    logic [7:0]  data_o;
    logic        data_valid_o;
    logic [3:0]  ems_window_hit_o;

    // Fields of the current test line
    logic [7:0]  op_code;
    int          t_en;
    int          t_tandy;
    int          t_base;
    int          t_aen;
    logic [19:0] t_addr;
    logic [7:0]  t_data;
    logic [7:0]  t_expect;
    int          t_valid;

    int          line_number;
    int          cycle_count;
    int          limit_cycles;

    periph_glue_top i_periph_glue_top (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .data_i             (data_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_mode_i       (tandy_mode_i),
        .ems_base_i         (ems_base_i),
        .data_o             (data_o),
        .data_valid_o       (data_valid_o),
        .ems_window_hit_o   (ems_window_hit_o)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // Cycle watchdog armed once the test file has been counted
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count = cycle_count + 1;
            if (limit_cycles != 0 && cycle_count > limit_cycles) begin
                stop_run($sformatf("timeout, tests still running after %0d cycles",
                                   cycle_count));
            end
        end
    end

    function automatic bit is_test_line(input string text);
        byte first;
        if (text.len() == 0) begin
            return 1'b0;
        end
        first = text.getc(0);
        return !(first == "#" || first == "\n" || first == "\r" || first == " ");
    endfunction

    task automatic count_test_lines(output int count);
        int    fd;
        string text;
        count = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            stop_run("cannot open the test file");
        end
        while ($fgets(text, fd) != 0) begin
            if (is_test_line(text)) begin
                count = count + 1;
            end
        end
        $fclose(fd);
    endtask

    // Called right after a rising edge
    task automatic drive_bus(input logic read_n, input logic write_n);
        ems_enabled_i      <= t_en[0];
        tandy_mode_i       <= t_tandy[0];
        ems_base_i         <= t_base[1:0];
        address_enable_n_i <= t_aen[0];
        address_i          <= t_addr;
        data_i             <= t_data;
        io_read_n_i        <= read_n;
        io_write_n_i       <= write_n;
    endtask

    task automatic release_strobes();
        io_read_n_i  <= 1'b1;
        io_write_n_i <= 1'b1;
    endtask

    task automatic check_read(input logic [7:0] expected_data, input logic expected_valid);
        if (data_o !== expected_data) begin
            stop_run($sformatf("mismatch data_o expected 0x%02h actual 0x%02h (line %0d)",
                               expected_data, data_o, line_number));
        end
        if (data_valid_o !== expected_valid) begin
            stop_run($sformatf("mismatch data_valid_o expected 0x%0h actual 0x%0h (line %0d)",
                               expected_valid, data_valid_o, line_number));
        end
    endtask

    task automatic check_hits(input logic [3:0] expected_hits);
        if (ems_window_hit_o !== expected_hits) begin
            stop_run($sformatf("mismatch ems_window_hit_o expected 0x%0h actual 0x%0h (line %0d)",
                               expected_hits, ems_window_hit_o, line_number));
        end
    endtask

    // Strobe low for one cycle, then two idle cycles
    task automatic write_cycle();
        @(posedge clock);
        drive_bus(1'b1, 1'b0);
        @(posedge clock);
        release_strobes();
        @(posedge clock);
    endtask

    task automatic read_cycle();
        @(posedge clock);
        drive_bus(1'b0, 1'b1);
        @(posedge clock);
        release_strobes();
        @(negedge clock);
        check_read(t_expect, t_valid[0]);
        // Bus falls back to idle one cycle later
        @(negedge clock);
        check_read(`IDLE_READ_VALUE, 1'b0);
    endtask

    // Nonzero data holds the I/O read strobe low during the probe
    task automatic probe_memory();
        @(posedge clock);
        drive_bus(t_data == 8'h00, 1'b1);
        @(negedge clock);
        check_hits(t_expect[3:0]);
        @(posedge clock);
        release_strobes();
    endtask

    initial begin
        int    fd;
        int    fields;
        int    test_count;
        string text;
        reset              = 1'b1;
        address_i          = 20'h00000;
        data_i             = 8'h00;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b1;
        address_enable_n_i = 1'b1;
        ems_enabled_i      = 1'b0;
        tandy_mode_i       = 1'b0;
        ems_base_i         = 2'd0;
        line_number        = 0;
        limit_cycles       = 0;

        count_test_lines(test_count);
        if (test_count == 0) begin
            stop_run("the test file holds no test lines");
        end
        limit_cycles = 4 * test_count * 4;

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            stop_run("cannot open the test file");
        end
        while ($fgets(text, fd) != 0) begin
            line_number = line_number + 1;
            if (is_test_line(text)) begin
                fields = $sscanf(text, "%c %d %d %d %d %h %h %h %d", op_code, t_en, t_tandy,
                                 t_base, t_aen, t_addr, t_data, t_expect, t_valid);
                if (fields != 9) begin
                    stop_run($sformatf("test line %0d could not be parsed", line_number));
                end
                case (op_code)
                    "W":     write_cycle();
                    "R":     read_cycle();
                    "M":     probe_memory();
                    default: stop_run($sformatf("unknown operation on test line %0d",
                                                line_number));
                endcase
            end
        end
        $fclose(fd);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
rtl/periph_glue_pkg.sv
rtl/port_decode.sv
rtl/ems_page_mapper.sv
rtl/port_latches.sv
rtl/read_data_mux.sv
rtl/periph_glue_top.sv
test/periph_glue_tb.sv

/* run.sh */
#!/bin/sh
# Build the peripheral glue testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f build.f \
    --top-module periph_glue_tb -o periph_glue_sim &&
./obj_dir/periph_glue_sim || exit 1

/* test/periph_glue_tests.txt */
# op en tandy base aen_n address(hex) data(hex) expect(hex) valid
# W ignores expect and valid, R expects data_o and valid, M expects hits (data 01 = I/O read low)
# Reset contents
R 0 0 0 0 00378 00 FF 1
R 0 1 0 0 000A3 00 FF 1
R 1 0 0 0 00260 00 FF 1
R 1 0 2 0 00263 00 FF 1
M 1 0 0 0 A0000 00 0 0
M 1 0 2 0 DC000 00 0 0
# EMS write rule, one slot at a time
W 1 0 0 0 00260 12 00 0
W 1 0 0 0 00261 05 00 0
W 1 0 0 0 00262 7F 00 0
W 1 0 0 0 00263 40 00 0
R 1 0 0 0 00260 00 12 1
R 1 0 0 0 00261 00 05 1
R 1 0 0 0 00262 00 7F 1
R 1 0 0 0 00263 00 40 1
W 1 0 0 0 00261 85 00 0
R 1 0 0 0 00261 00 05 1
W 1 0 0 0 00262 FF 00 0
R 1 0 0 0 00262 00 FF 1
# Window decode for each base
M 1 0 1 0 C8000 00 0 0
W 1 0 0 0 00262 33 00 0
R 1 0 0 0 00262 00 33 1
M 1 0 0 0 A0000 00 1 0
M 1 0 0 0 A4000 00 2 0
M 1 0 1 0 C8000 00 4 0
M 1 0 2 0 DC000 00 8 0
M 1 0 3 0 DC000 00 8 0
M 1 0 2 0 D3FFF 00 1 0
M 1 0 0 0 C8000 00 0 0
M 1 0 1 0 C8000 01 0 0
W 1 0 0 0 00261 FF 00 0
M 1 0 0 0 A4000 00 0 0
R 1 0 0 0 00261 00 FF 1
# Printer latch and NMI mask
W 0 0 0 0 00378 A5 00 0
R 0 0 0 0 00378 00 A5 1
W 0 1 0 0 000A0 3C 00 0
R 0 1 0 0 000A7 00 3C 1
W 0 0 0 0 000A0 55 00 0
R 0 0 0 0 000A0 00 00 0
R 0 1 0 0 000A3 00 3C 1
# Decode qualification
W 0 0 0 1 00378 11 00 0
R 0 0 0 1 00378 00 00 0
R 0 0 0 0 00378 00 A5 1
W 1 0 0 1 00263 22 00 0
R 1 0 0 0 00263 00 40 1
W 0 0 0 0 00260 22 00 0
R 0 0 0 0 00260 00 00 0
R 1 0 0 0 00260 00 12 1
W 1 0 0 0 00264 01 00 0
R 1 0 0 0 00264 00 00 0
R 1 0 0 0 00260 00 12 1
W 0 0 0 0 00379 77 00 0
R 0 0 0 0 00379 00 00 0
R 0 0 0 0 00378 00 A5 1
W 0 1 0 0 000A8 99 00 0
R 0 1 0 0 000A8 00 00 0
R 0 1 0 0 000A0 00 3C 1
